//--- logic/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int DATA_W = 32;

    // Iterations of the multiply/divide unit
    localparam int MULDIV_STEPS = 32;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        LUI,
        PCADD,
        JUMP,
        MUL,
        MULHU,
        DIVU,
        MODU,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        NOP
    } alu_op_e;

endpackage

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t;

    // One enable per byte lane
    typedef logic [3:0] byte_sel_t;

    // Encoding matches the cache request type field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire

//--- logic/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::alu_op_e aluop_i,
    input  wire ex_pkg::data_t   oprand1_i,
    input  wire ex_pkg::data_t   oprand2_i,
    input  wire ex_pkg::data_t   pc_i,
    input  wire ex_pkg::data_t   muldiv_result_i,
    output ex_pkg::data_t        result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = oprand2_i[4:0];
    assign lt_signed   = $signed(oprand1_i) < $signed(oprand2_i);
    assign lt_unsigned = oprand1_i < oprand2_i;

    always_comb begin
        case (aluop_i)
            ADD:   result_o = oprand1_i + oprand2_i;
            SUB:   result_o = oprand1_i - oprand2_i;
            SLT:   result_o = {{(DATA_W-1){1'b0}}, lt_signed};
            SLTU:  result_o = {{(DATA_W-1){1'b0}}, lt_unsigned};
            AND:   result_o = oprand1_i & oprand2_i;
            OR:    result_o = oprand1_i | oprand2_i;
            XOR:   result_o = oprand1_i ^ oprand2_i;
            NOR:   result_o = ~(oprand1_i | oprand2_i);
            SLL:   result_o = oprand1_i << shamt;
            SRL:   result_o = oprand1_i >> shamt;
            SRA:   result_o = data_t'($signed(oprand1_i) >>> shamt);
            // Immediate already placed in the upper bits
            LUI:   result_o = oprand2_i;
            PCADD: result_o = pc_i + oprand2_i;
            // Link address
            JUMP:  result_o = pc_i + data_t'(4);
            MUL, MULHU, DIVU, MODU: begin
                result_o = muldiv_result_i;
            end
            // Loads write back in the memory stage
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ex_muldiv.sv
`timescale 1ns/100ps
`default_nettype none

module ex_muldiv (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire ex_pkg::alu_op_e aluop_i,
    input  wire logic            valid_i,
    input  wire ex_pkg::data_t   oprand1_i,
    input  wire ex_pkg::data_t   oprand2_i,
    input  wire logic            advance_i,
    input  wire logic            flush_i,
    output logic                 done_ready_o,
    output ex_pkg::data_t        result_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(MULDIV_STEPS);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e           state_q;
    logic             started_q;
    logic [CNT_W-1:0] step_q;
    data_t            hi_q;
    data_t            lo_q;
    data_t            opb_q;
    data_t            hi_nxt;
    data_t            lo_nxt;
    data_t            result_q;
    logic [DATA_W:0]  sum;
    logic [DATA_W:0]  diff;
    logic             is_md;
    logic             is_div;
    logic             start;
    logic             done;

    assign is_md  = aluop_i inside {MUL, MULHU, DIVU, MODU};
    assign is_div = aluop_i inside {DIVU, MODU};

    // A held instruction starts once
    assign start = valid_i & is_md & ~started_q & ~flush_i & (state_q == IDLE);
    assign done  = (state_q == RUN) & (step_q == CNT_W'(MULDIV_STEPS - 1));

    ////////////////////
    // One iteration

    always_comb begin
        sum  = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opb_q} : '0);
        diff = {hi_q, lo_q[DATA_W-1]} - {1'b0, opb_q};
        if (is_div) begin
            // Restore when the trial subtract borrows
            if (!diff[DATA_W]) begin
                hi_nxt = diff[DATA_W-1:0];
                lo_nxt = {lo_q[DATA_W-2:0], 1'b1};
            end else begin
                hi_nxt = {hi_q[DATA_W-2:0], lo_q[DATA_W-1]};
                lo_nxt = {lo_q[DATA_W-2:0], 1'b0};
            end
        end else begin
            // Product shifts right with the carry entering at the top
            {hi_nxt, lo_nxt} = {sum, lo_q[DATA_W-1:1]};
        end
    end

    ////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            started_q <= 1'b0;
            step_q    <= '0;
        end else if (advance_i || flush_i) begin
            state_q   <= IDLE;
            started_q <= 1'b0;
        end else begin
            if (start) begin
                started_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= RUN;
                        step_q  <= '0;
                    end
                end
                RUN: begin
                    if (done) begin
                        state_q <= DONE;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: state_q <= state_q;
            endcase
        end
    end

    // {hi, lo} holds product or remainder and quotient
    always_ff @(posedge clk) begin
        if (start) begin
            hi_q  <= '0;
            lo_q  <= oprand1_i;
            // Zero divisor acts as one
            opb_q <= (is_div && oprand2_i == '0) ? data_t'(1) : oprand2_i;
        end else if (state_q == RUN) begin
            hi_q <= hi_nxt;
            lo_q <= lo_nxt;
        end
        if (done) begin
            result_q <= (aluop_i == MUL || aluop_i == DIVU) ? lo_nxt : hi_nxt;
        end
    end

    assign done_ready_o = (state_q == DONE);
    assign result_o     = result_q;

endmodule

`default_nettype wire

//--- logic/ex_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_lsu (
    input  wire ex_pkg::alu_op_e aluop_i,
    input  wire logic            valid_i,
    input  wire logic            advance_i,
    input  wire ex_pkg::data_t   oprand1_i,
    input  wire ex_pkg::data_t   oprand2_i,
    input  wire ex_pkg::data_t   imm_i,
    input  wire logic            dcache_ready_i,
    output mem_pkg::addr_t       mem_addr_o,
    output logic                 excp_ale_o,
    output logic                 is_mem_o,
    output logic                 dcache_ce_o,
    output logic                 dcache_we_o,
    output mem_pkg::mem_size_e   dcache_size_o,
    output mem_pkg::byte_sel_t   dcache_sel_o,
    output ex_pkg::data_t        dcache_data_o
);
    import ex_pkg::*;
    import mem_pkg::*;

    logic       is_store;
    mem_size_e  size;
    byte_sel_t  sel;
    data_t      wdata;
    logic [4:0] lane_shift;

    assign mem_addr_o = oprand1_i + imm_i;
    assign lane_shift = {mem_addr_o[1:0], 3'b000};
    assign is_store   = aluop_i inside {ST_B, ST_H, ST_W};
    assign is_mem_o   = is_store | (aluop_i inside {LD_B, LD_BU, LD_H, LD_HU, LD_W});

    always_comb begin
        case (aluop_i)
            LD_B, LD_BU, ST_B: begin
                size  = SIZE_BYTE;
                sel   = byte_sel_t'(4'b0001 << mem_addr_o[1:0]);
                wdata = data_t'({24'b0, oprand2_i[7:0]} << lane_shift);
            end
            LD_H, LD_HU, ST_H: begin
                size  = SIZE_HALF;
                sel   = byte_sel_t'(4'b0011 << mem_addr_o[1:0]);
                wdata = data_t'({16'b0, oprand2_i[15:0]} << lane_shift);
            end
            default: begin
                size  = SIZE_WORD;
                sel   = 4'b1111;
                wdata = oprand2_i;
            end
        endcase
    end

    // Byte accesses never fault
    assign excp_ale_o = is_mem_o & (((size == SIZE_HALF) & mem_addr_o[0])
                                  | ((size == SIZE_WORD) & (mem_addr_o[1:0] != 2'b00)));

    // Request only in the advance cycle with all fields zero otherwise
    assign dcache_ce_o   = advance_i & valid_i & is_mem_o & dcache_ready_i;
    assign dcache_we_o   = dcache_ce_o & is_store;
    assign dcache_size_o = dcache_ce_o ? size : SIZE_BYTE;
    assign dcache_sel_o  = dcache_ce_o ? sel : '0;
    assign dcache_data_o = dcache_we_o ? wdata : '0;

endmodule

`default_nettype wire

//--- logic/ex_mem_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_reg (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush_i,
    input  wire logic              advance_i,
    input  wire logic              valid_i,
    input  wire ex_pkg::data_t     wdata_i,
    input  wire ex_pkg::reg_addr_t waddr_i,
    input  wire logic              wreg_i,
    input  wire mem_pkg::addr_t    addr_i,
    input  wire logic              excp_ale_i,
    output logic                   mem_valid_o,
    output ex_pkg::data_t          mem_wdata_o,
    output ex_pkg::reg_addr_t      mem_waddr_o,
    output logic                   mem_wreg_o,
    output mem_pkg::addr_t         mem_addr_o,
    output logic                   mem_excp_ale_o
);

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem_valid_o    <= 1'b0;
            mem_wdata_o    <= '0;
            mem_waddr_o    <= '0;
            mem_wreg_o     <= 1'b0;
            mem_addr_o     <= '0;
            mem_excp_ale_o <= 1'b0;
        end else if (advance_i) begin
            mem_valid_o    <= valid_i;
            mem_wdata_o    <= wdata_i;
            mem_waddr_o    <= waddr_i;
            // No register write from a bubble
            mem_wreg_o     <= wreg_i & valid_i;
            mem_addr_o     <= addr_i;
            mem_excp_ale_o <= excp_ale_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              valid_i,
    input  wire ex_pkg::alu_op_e   aluop_i,
    input  wire ex_pkg::data_t     oprand1_i,
    input  wire ex_pkg::data_t     oprand2_i,
    input  wire ex_pkg::data_t     imm_i,
    input  wire ex_pkg::data_t     pc_i,
    input  wire ex_pkg::reg_addr_t waddr_i,
    input  wire logic              wreg_i,
    input  wire logic              advance_i,
    input  wire logic              flush_i,
    input  wire logic              dcache_ready_i,
    output logic                   advance_ready_o,
    output logic                   mem_valid_o,
    output ex_pkg::data_t          mem_wdata_o,
    output ex_pkg::reg_addr_t      mem_waddr_o,
    output logic                   mem_wreg_o,
    output mem_pkg::addr_t         mem_addr_o,
    output logic                   mem_excp_ale_o,
    output logic                   dcache_ce_o,
    output logic                   dcache_we_o,
    output mem_pkg::mem_size_e     dcache_size_o,
    output mem_pkg::byte_sel_t     dcache_sel_o,
    output mem_pkg::addr_t         dcache_addr_o,
    output ex_pkg::data_t          dcache_data_o
);
    import ex_pkg::*;
    import mem_pkg::*;

    data_t alu_result;
    data_t md_result;
    logic  md_done_ready;
    addr_t lsu_addr;
    logic  lsu_excp;
    logic  lsu_is_mem;
    logic  is_md;

    ////////////////////
    // Result producers

    ex_muldiv u_muldiv (
        .clk          (clk),
        .rst          (rst),
        .aluop_i      (aluop_i),
        .valid_i      (valid_i),
        .oprand1_i    (oprand1_i),
        .oprand2_i    (oprand2_i),
        .advance_i    (advance_i),
        .flush_i      (flush_i),
        .done_ready_o (md_done_ready),
        .result_o     (md_result)
    );

    ex_alu u_alu (
        .aluop_i         (aluop_i),
        .oprand1_i       (oprand1_i),
        .oprand2_i       (oprand2_i),
        .pc_i            (pc_i),
        .muldiv_result_i (md_result),
        .result_o        (alu_result)
    );

    ex_lsu u_lsu (
        .aluop_i        (aluop_i),
        .valid_i        (valid_i),
        .advance_i      (advance_i),
        .oprand1_i      (oprand1_i),
        .oprand2_i      (oprand2_i),
        .imm_i          (imm_i),
        .dcache_ready_i (dcache_ready_i),
        .mem_addr_o     (lsu_addr),
        .excp_ale_o     (lsu_excp),
        .is_mem_o       (lsu_is_mem),
        .dcache_ce_o    (dcache_ce_o),
        .dcache_we_o    (dcache_we_o),
        .dcache_size_o  (dcache_size_o),
        .dcache_sel_o   (dcache_sel_o),
        .dcache_data_o  (dcache_data_o)
    );

    assign dcache_addr_o = dcache_ce_o ? lsu_addr : '0;

    ////////////////////
    // Stage output register

    ex_mem_reg u_ex_mem_reg (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .advance_i      (advance_i),
        .valid_i        (valid_i),
        .wdata_i        (alu_result),
        .waddr_i        (waddr_i),
        .wreg_i         (wreg_i),
        .addr_i         (lsu_addr),
        .excp_ale_i     (lsu_excp),
        .mem_valid_o    (mem_valid_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_waddr_o    (mem_waddr_o),
        .mem_wreg_o     (mem_wreg_o),
        .mem_addr_o     (mem_addr_o),
        .mem_excp_ale_o (mem_excp_ale_o)
    );

    // Memory ops wait on the cache, mul/div on its result
    assign is_md = aluop_i inside {MUL, MULHU, DIVU, MODU};

    always_comb begin
        if (valid_i && lsu_is_mem) begin
            advance_ready_o = dcache_ready_i;
        end else if (valid_i && is_md) begin
            advance_ready_o = md_done_ready;
        end else begin
            advance_ready_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- testbench/ex_stage_properties.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic advance_i,
    input wire logic flush_i,
    input wire logic advance_ready_i,
    input wire logic dcache_ce_i,
    input wire logic mem_valid_i
);

    int fail_count = 0;

    advance_needs_ready: assert property (
        @(posedge clk) disable iff (rst) advance_i |-> advance_ready_i
    ) else begin
        fail_count++;
        $error("advance_i asserted while advance_ready_o is low");
    end

    request_needs_advance: assert property (
        @(posedge clk) disable iff (rst) dcache_ce_i |-> advance_i
    ) else begin
        fail_count++;
        $error("dcache_ce_o asserted without advance_i");
    end

    // Register is empty one cycle after a flush
    flush_clears_valid: assert property (
        @(posedge clk) disable iff (rst) flush_i |=> !mem_valid_i
    ) else begin
        fail_count++;
        $error("mem_valid_o still high after flush_i");
    end

endmodule

bind ex_stage ex_stage_properties props_i (
    .clk             (clk),
    .rst             (rst),
    .advance_i       (advance_i),
    .flush_i         (flush_i),
    .advance_ready_i (advance_ready_o),
    .dcache_ce_i     (dcache_ce_o),
    .mem_valid_i     (mem_valid_o)
);

`default_nettype wire

//--- testbench/tb_ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;
    import mem_pkg::*;

    localparam int N_INSTR    = 400;
    localparam int TIMEOUT_NS = (N_INSTR + 2) * (MULDIV_STEPS + 10) * 100;

    logic      clk;
    logic      rst;
    logic      valid_i;
    alu_op_e   aluop_i;
    data_t     oprand1_i;
    data_t     oprand2_i;
    data_t     imm_i;
    data_t     pc_i;
    reg_addr_t waddr_i;
    logic      wreg_i;
    logic      advance_i;
    logic      flush_i;
    logic      dcache_ready_i;
    logic      advance_ready_o;
    logic      mem_valid_o;
    data_t     mem_wdata_o;
    reg_addr_t mem_waddr_o;
    logic      mem_wreg_o;
    addr_t     mem_addr_o;
    logic      mem_excp_ale_o;
    logic      dcache_ce_o;
    logic      dcache_we_o;
    mem_size_e dcache_size_o;
    byte_sel_t dcache_sel_o;
    addr_t     dcache_addr_o;
    data_t     dcache_data_o;

    integer seed = 32'hf8fb_2700;

    ex_stage dut_i (
        .clk             (clk),
        .rst             (rst),
        .valid_i         (valid_i),
        .aluop_i         (aluop_i),
        .oprand1_i       (oprand1_i),
        .oprand2_i       (oprand2_i),
        .imm_i           (imm_i),
        .pc_i            (pc_i),
        .waddr_i         (waddr_i),
        .wreg_i          (wreg_i),
        .advance_i       (advance_i),
        .flush_i         (flush_i),
        .dcache_ready_i  (dcache_ready_i),
        .advance_ready_o (advance_ready_o),
        .mem_valid_o     (mem_valid_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_waddr_o     (mem_waddr_o),
        .mem_wreg_o      (mem_wreg_o),
        .mem_addr_o      (mem_addr_o),
        .mem_excp_ale_o  (mem_excp_ale_o),
        .dcache_ce_o     (dcache_ce_o),
        .dcache_we_o     (dcache_we_o),
        .dcache_size_o   (dcache_size_o),
        .dcache_sel_o    (dcache_sel_o),
        .dcache_addr_o   (dcache_addr_o),
        .dcache_data_o   (dcache_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the stage stopped making progress before all instructions ran");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        wait (dut_i.props_i.fail_count != 0);
        $display("An assertion in the bound stage checker failed at %0t", $time);
        $display("test failed");
        $fatal(1);
    end

    ////////////////////
    // Compare tasks

    task automatic check_data(input data_t act, input data_t exp, input string msg);
        if (act !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, msg, act, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_sel(input byte_sel_t act, input byte_sel_t exp, input string msg);
        if (act !== exp) begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, msg, act, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_size(input mem_size_e act, input mem_size_e exp, input string msg);
        if (act !== exp) begin
            $display("FAILED at %0t: %s, got %0d expected %0d", $time, msg, act, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string msg);
        if (act !== exp) begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, msg, act, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    ////////////////////
    // Reference model

    function automatic data_t model_result(alu_op_e op, data_t a, data_t b, data_t pc);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            ADD:   return a + b;
            SUB:   return a - b;
            SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:  return (a < b) ? 32'd1 : 32'd0;
            AND:   return a & b;
            OR:    return a | b;
            XOR:   return a ^ b;
            NOR:   return ~(a | b);
            SLL:   return a << b[4:0];
            SRL:   return a >> b[4:0];
            SRA:   return $signed(a) >>> b[4:0];
            LUI:   return b;
            PCADD: return pc + b;
            JUMP:  return pc + 32'd4;
            MUL:   return prod[31:0];
            MULHU: return prod[63:32];
            DIVU:  return (b == 0) ? a : a / b;
            MODU:  return (b == 0) ? 32'd0 : a % b;
            default: return 32'd0;
        endcase
    endfunction

    function automatic mem_size_e model_size(alu_op_e op);
        if (op inside {LD_B, LD_BU, ST_B}) begin
            return SIZE_BYTE;
        end
        if (op inside {LD_H, LD_HU, ST_H}) begin
            return SIZE_HALF;
        end
        return SIZE_WORD;
    endfunction

    // Lanes covered by the access, starting at its byte offset
    function automatic byte_sel_t model_sel(mem_size_e sz, addr_t addr);
        byte_sel_t sel;
        int        off;
        int        n;
        off = (sz == SIZE_WORD) ? 0 : int'(addr[1:0]);
        n   = (sz == SIZE_BYTE) ? 1 : ((sz == SIZE_HALF) ? 2 : 4);
        for (int i = 0; i < 4; i++) begin
            sel[i] = (i >= off) && (i < off + n);
        end
        return sel;
    endfunction

    function automatic data_t model_wdata(mem_size_e sz, addr_t addr, data_t b);
        data_t     d;
        byte_sel_t sel;
        int        off;
        sel = model_sel(sz, addr);
        off = (sz == SIZE_WORD) ? 0 : int'(addr[1:0]);
        d   = '0;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                d[8*i +: 8] = b[8*(i-off) +: 8];
            end
        end
        return d;
    endfunction

    ////////////////////
    // One instruction

    task automatic run_one();
        alu_op_e   op;
        data_t     a;
        data_t     b;
        data_t     imm;
        data_t     pc;
        reg_addr_t wa;
        logic      wr;
        logic      is_mem;
        logic      is_md;
        logic      is_store;
        logic      do_flush;
        int        stall;
        int        waited;
        addr_t     addr;
        mem_size_e sz;
        logic [31:0] r;

        r        = $unsigned($random(seed)) % 27;
        op       = alu_op_e'(r[4:0]);
        a        = $random(seed);
        b        = $random(seed);
        imm      = $random(seed);
        pc       = $random(seed) & 32'hffff_fffc;
        wa       = reg_addr_t'($random(seed));
        wr       = 1'($random(seed));
        is_mem   = op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, ST_B, ST_H, ST_W};
        is_md    = op inside {MUL, MULHU, DIVU, MODU};
        is_store = op inside {ST_B, ST_H, ST_W};
        do_flush = ($unsigned($random(seed)) % 12) == 0;
        stall    = (is_mem && ($unsigned($random(seed)) % 3 == 0))
                 ? 1 + $unsigned($random(seed)) % 4 : 0;
        // Small addresses, and now and then a zero divisor
        if (is_mem) begin
            a   = a & 32'h0000_00ff;
            imm = imm & 32'h0000_003f;
        end
        if (op inside {DIVU, MODU} && ($unsigned($random(seed)) % 4 == 0)) begin
            b = '0;
        end
        addr = a + imm;
        sz   = model_size(op);

        @(posedge clk);
        valid_i   <= 1'b1;
        aluop_i   <= op;
        oprand1_i <= a;
        oprand2_i <= b;
        imm_i     <= imm;
        pc_i      <= pc;
        waddr_i   <= wa;
        wreg_i    <= wr;
        advance_i <= 1'b0;
        flush_i   <= 1'b0;
        if (stall > 0) begin
            dcache_ready_i <= 1'b0;
        end

        @(negedge clk);
        check_bit(advance_ready_o, !(is_md || stall > 0), "advance_ready_o on issue");
        check_bit(dcache_ce_o, 1'b0, "dcache_ce_o before advance");

        if (do_flush) begin
            @(posedge clk);
            flush_i        <= 1'b1;
            dcache_ready_i <= 1'b1;
            @(posedge clk);
            flush_i <= 1'b0;
            valid_i <= 1'b0;
            aluop_i <= NOP;
            @(negedge clk);
            check_bit(mem_valid_o, 1'b0, "mem_valid_o after flush");
            check_bit(mem_wreg_o, 1'b0, "mem_wreg_o after flush");
        end else begin
            waited = 0;
            while (!advance_ready_o) begin
                check_bit(dcache_ce_o, 1'b0, "dcache_ce_o while stalled");
                waited++;
                @(posedge clk);
                if (is_mem && waited >= stall) begin
                    dcache_ready_i <= 1'b1;
                end
                @(negedge clk);
            end
            if (is_mem) begin
                check_bit(waited == stall, 1'b1, "memory op stall length");
            end
            if (is_md) begin
                check_bit(waited == MULDIV_STEPS + 1, 1'b1, "mul/div latency");
            end

            @(posedge clk);
            advance_i <= 1'b1;
            @(negedge clk);
            check_bit(dcache_ce_o, is_mem, "dcache_ce_o");
            check_bit(dcache_we_o, is_store, "dcache_we_o");
            check_size(dcache_size_o, is_mem ? sz : SIZE_BYTE, "dcache_size_o");
            check_sel(dcache_sel_o, is_mem ? model_sel(sz, addr) : 4'b0000, "dcache_sel_o");
            check_data(dcache_addr_o, is_mem ? addr : 32'd0, "dcache_addr_o");
            check_data(dcache_data_o, is_store ? model_wdata(sz, addr, b) : 32'd0,
                       "dcache_data_o");

            @(posedge clk);
            advance_i <= 1'b0;
            valid_i   <= 1'b0;
            aluop_i   <= NOP;
            @(negedge clk);
            check_bit(mem_valid_o, 1'b1, "mem_valid_o");
            check_data(mem_wdata_o, model_result(op, a, b, pc), "mem_wdata_o");
            check_data(data_t'(mem_waddr_o), data_t'(wa), "mem_waddr_o");
            check_bit(mem_wreg_o, wr, "mem_wreg_o");
            check_data(mem_addr_o, addr, "mem_addr_o");
            check_bit(mem_excp_ale_o,
                      is_mem && ((sz == SIZE_HALF && addr[0])
                              || (sz == SIZE_WORD && addr[1:0] != 2'b00)),
                      "mem_excp_ale_o");
        end
    endtask

    initial begin
        rst            = 1'b1;
        valid_i        = 1'b0;
        aluop_i        = NOP;
        oprand1_i      = '0;
        oprand2_i      = '0;
        imm_i          = '0;
        pc_i           = '0;
        waddr_i        = '0;
        wreg_i         = 1'b0;
        advance_i      = 1'b0;
        flush_i        = 1'b0;
        dcache_ready_i = 1'b1;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit(mem_valid_o, 1'b0, "mem_valid_o after reset");
        check_bit(mem_wreg_o, 1'b0, "mem_wreg_o after reset");
        check_bit(mem_excp_ale_o, 1'b0, "mem_excp_ale_o after reset");
        check_bit(dcache_ce_o, 1'b0, "dcache_ce_o after reset");

        for (int n = 0; n < N_INSTR; n++) begin
            run_one();
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/ex_pkg.sv
logic/mem_pkg.sv
logic/ex_alu.sv
logic/ex_muldiv.sv
logic/ex_lsu.sv
logic/ex_mem_reg.sv
logic/ex_stage.sv
testbench/ex_stage_properties.sv
testbench/tb_ex_stage.sv
